// ==== Bender.yml ====
package:
  name: async_fifo

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/fifo_pkg.sv
      - hdl/fifo_dual_port_ram.sv
      - hdl/fifo_wr_ctrl.sv
      - hdl/fifo_rd_ctrl.sv
      - hdl/async_fifo.sv
  - target: test
    files:
      - verification/async_fifo_tb.sv

// ==== filelist.f ====
+incdir+hdl
hdl/fifo_pkg.sv
hdl/fifo_dual_port_ram.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/async_fifo.sv
verification/async_fifo_tb.sv

// ==== hdl/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  fifo_pkg::fifo_data_t      wr_data,
  output fifo_pkg::fifo_wr_status_t wr_status,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  output fifo_pkg::fifo_data_t      rd_data,
  output fifo_pkg::fifo_rd_status_t rd_status
);

  import fifo_pkg::*;

  logic       ram_wr_en;
  fifo_addr_t ram_wr_addr;
  logic       ram_rd_en;
  fifo_addr_t ram_rd_addr;
  fifo_ptr_t  wr_gray_ptr; // only gray pointers cross domains.
  fifo_ptr_t  rd_gray_ptr;

  fifo_dual_port_ram ram_i (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (ram_wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (ram_rd_addr),
    .rd_data  (rd_data)
  );

  fifo_wr_ctrl wr_ctrl_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_gray_ptr (rd_gray_ptr),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_gray_ptr (wr_gray_ptr),
    .wr_status   (wr_status)
  );

  fifo_rd_ctrl rd_ctrl_i (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_gray_ptr (wr_gray_ptr),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_gray_ptr (rd_gray_ptr),
    .rd_status   (rd_status)
  );

endmodule

// ==== hdl/fifo_dual_port_ram.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_dual_port_ram (
  input  logic                 wr_clk,
  input  logic                 wr_en,
  input  fifo_pkg::fifo_addr_t wr_addr,
  input  fifo_pkg::fifo_data_t wr_data,
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  input  fifo_pkg::fifo_addr_t rd_addr,
  output fifo_pkg::fifo_data_t rd_data
);

  import fifo_pkg::*;

  fifo_data_t mem [`FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // output register holds the last word read until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  a_wr_addr_known: assert property (
    @(posedge wr_clk) wr_en |-> !$isunknown(wr_addr)
  ) else $error("ram write with unknown address.");

endmodule

// ==== hdl/fifo_macros.svh ====
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// word and storage geometry.
`define FIFO_DATA_WIDTH 8
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

// afull is set at or above this write-side level.
`define FIFO_AFULL_LEVEL 14

// aempty is set at or below this read-side level.
`define FIFO_AEMPTY_LEVEL 2

`endif

// ==== hdl/fifo_pkg.sv ====
`include "fifo_macros.svh"

package fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_ptr_t; // address plus wrap bit.

  typedef struct packed {
    logic full;
    logic afull;
  } fifo_wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } fifo_rd_status_t;

  function automatic fifo_ptr_t bin2gray(fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at and above it.
  function automatic fifo_ptr_t gray2bin(fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin = gray;
    for (int i = 1; i < $bits(fifo_ptr_t); i++) begin
      bin = bin ^ (gray >> i);
    end
    return bin;
  endfunction

endpackage

// ==== hdl/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_rd_ctrl (
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  input  fifo_pkg::fifo_ptr_t       wr_gray_ptr,
  output logic                      ram_rd_en,
  output fifo_pkg::fifo_addr_t      ram_rd_addr,
  output fifo_pkg::fifo_ptr_t       rd_gray_ptr,
  output fifo_pkg::fifo_rd_status_t rd_status
);

  import fifo_pkg::*;

  logic            rd_accept;
  fifo_ptr_t       rd_bin;
  fifo_ptr_t       rd_bin_nxt;
  fifo_ptr_t       rd_gray_nxt;
  fifo_ptr_t       wr_gray_sync1;
  fifo_ptr_t       wr_gray_sync2;
  fifo_ptr_t       wr_bin_sync;
  fifo_ptr_t       level_nxt;
  fifo_rd_status_t status_nxt;

  assign rd_accept   = rd_en && !rd_status.empty; // reads while empty are ignored.
  assign rd_bin_nxt  = rd_bin + fifo_ptr_t'(rd_accept);
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);

  assign ram_rd_en   = rd_accept;
  assign ram_rd_addr = rd_bin[`FIFO_ADDR_WIDTH-1:0];

  // write pointer into the read domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_gray_ptr;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  assign wr_bin_sync = gray2bin(wr_gray_sync2);
  assign level_nxt   = wr_bin_sync - rd_bin_nxt;

  // gray codes match exactly when the binary pointers do.
  assign status_nxt.empty  = (rd_gray_nxt == wr_gray_sync2);
  assign status_nxt.aempty = (level_nxt <= fifo_ptr_t'(`FIFO_AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_gray_ptr <= '0;
      rd_status   <= '1; // empty and aempty out of reset.
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_gray_ptr <= rd_gray_nxt;
      rd_status   <= status_nxt;
    end
  end

  a_no_read_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |=> $stable(rd_bin)
  ) else $error("read pointer moved while empty.");

  // a multi-bit step means the synchronizer caught a torn pointer.
  a_sync_one_bit_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(wr_gray_sync2 ^ $past(wr_gray_sync2)) <= 1
  ) else $error("synchronized write pointer changed by more than one bit.");

endmodule

// ==== hdl/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifo_wr_ctrl (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  fifo_pkg::fifo_ptr_t       rd_gray_ptr,
  output logic                      ram_wr_en,
  output fifo_pkg::fifo_addr_t      ram_wr_addr,
  output fifo_pkg::fifo_ptr_t       wr_gray_ptr,
  output fifo_pkg::fifo_wr_status_t wr_status
);

  import fifo_pkg::*;

  logic            wr_accept;
  fifo_ptr_t       wr_bin;
  fifo_ptr_t       wr_bin_nxt;
  fifo_ptr_t       wr_gray_nxt;
  fifo_ptr_t       rd_gray_sync1;
  fifo_ptr_t       rd_gray_sync2;
  fifo_ptr_t       rd_bin_sync;
  fifo_ptr_t       level_nxt;
  fifo_wr_status_t status_nxt;

  assign wr_accept   = wr_en && !wr_status.full; // writes while full are dropped.
  assign wr_bin_nxt  = wr_bin + fifo_ptr_t'(wr_accept);
  assign wr_gray_nxt = bin2gray(wr_bin_nxt);

  assign ram_wr_en   = wr_accept;
  assign ram_wr_addr = wr_bin[`FIFO_ADDR_WIDTH-1:0];

  // read pointer into the write domain.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_gray_ptr;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  assign rd_bin_sync = gray2bin(rd_gray_sync2);

  // the stale read pointer makes this level pessimistic.
  assign level_nxt = wr_bin_nxt - rd_bin_sync;

  assign status_nxt.full  = (level_nxt == fifo_ptr_t'(`FIFO_DEPTH));
  assign status_nxt.afull = (level_nxt >= fifo_ptr_t'(`FIFO_AFULL_LEVEL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_gray_ptr <= '0;
      wr_status   <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_gray_ptr <= wr_gray_nxt;
      wr_status   <= status_nxt; // flags track the pointer they are built from.
    end
  end

  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |=> $stable(wr_bin)
  ) else $error("write pointer moved while full.");

  a_level_in_range: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    level_nxt <= fifo_ptr_t'(`FIFO_DEPTH)
  ) else $error("write-side level above depth.");

endmodule

// ==== verification/async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb;

  import fifo_pkg::*;

  localparam int WR_HALF    = 7; // 14 ns write clock.
  localparam int RD_HALF    = 5; // 10 ns read clock.
  localparam int STIM_WORDS = 256;

  logic            wr_clk;
  logic            wr_rst_n;
  logic            wr_en;
  fifo_data_t      wr_data;
  fifo_wr_status_t wr_status;
  logic            rd_clk;
  logic            rd_rst_n;
  logic            rd_en;
  fifo_data_t      rd_data;
  fifo_rd_status_t rd_status;

  logic [15:0] stim_mem [STIM_WORDS];
  int          n_ops = 0;
  int          errors = 0;
  logic [31:0] lcg_state = 32'heacc_280c;

  async_fifo dut_i (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_status (rd_status)
  );

  initial begin
    wr_clk = 1'b0;
    forever #WR_HALF wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #RD_HALF rd_clk = ~rd_clk;
  end

  initial begin
    wr_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    repeat (2) @(negedge wr_clk);
    wr_rst_n = 1'b1;
  end

  initial begin
    rd_rst_n = 1'b0;
    rd_en    = 1'b0;
    repeat (2) @(negedge rd_clk);
    rd_rst_n = 1'b1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_check(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error.");
  endtask

  task automatic abort_run(input string msg);
    $display("ERRORS FOUND");
    $fatal(1, msg);
  endtask

  // caller is aligned to a falling wr_clk edge.
  task automatic push_word(input fifo_data_t data);
    while (wr_status.full) @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = data;
    @(negedge wr_clk);
    wr_en   = 1'b0;
  endtask

  // caller is aligned to a falling rd_clk edge.
  task automatic pop_word(input fifo_data_t exp);
    while (rd_status.empty) @(negedge rd_clk);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    assert (rd_data === exp)
      else fail_check($sformatf("read %02h, expected %02h.", rd_data, exp));
  endtask

  task automatic check_flags(input logic [3:0] exp);
    logic [3:0] got;
    repeat (6) @(negedge wr_clk); // lets both synchronizers settle.
    got[3:2] = {wr_status.full, wr_status.afull};
    @(negedge rd_clk);
    got[1:0] = {rd_status.empty, rd_status.aempty};
    assert (got === exp)
      else fail_check($sformatf("flags full/afull/empty/aempty %b, expected %b.", got, exp));
  endtask

  initial begin
    int n;
    wait (n_ops > 0);
    n = n_ops * 40 * 2 * WR_HALF;
    #(n);
    abort_run("timeout, the stimulus did not complete in time.");
  end

  initial begin
    int          count;
    logic [15:0] op;
    logic [15:0] val;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verification/fifo_stim.txt", stim_mem);
    count = 0;
    while (count < STIM_WORDS / 2 && stim_mem[2 * count] != 16'h0) count++;
    if (count == 0) begin
      abort_run("stimulus file is missing or holds no operations.");
    end
    n_ops = count;
    wait (wr_rst_n && rd_rst_n);
    for (int i = 0; i < n_ops; i++) begin
      op  = stim_mem[2 * i];
      val = stim_mem[2 * i + 1];
      case (op)
        16'h1: begin // write word.
          @(negedge wr_clk);
          push_word(val[7:0]);
        end
        16'h2: begin // read and compare.
          @(negedge rd_clk);
          pop_word(val[7:0]);
        end
        16'h3: begin // count in the high byte, start in the low byte.
          @(negedge wr_clk);
          for (int k = 0; k < val[15:8]; k++) push_word(val[7:0] + k);
        end
        16'h4: check_flags(val[3:0]);
        16'h5: repeat (val) @(negedge wr_clk);
        16'h6: begin // wr_en while full must be dropped.
          @(negedge wr_clk);
          assert (wr_status.full)
            else fail_check("fifo not full before the dropped write.");
          wr_en   = 1'b1;
          wr_data = val[7:0];
          @(negedge wr_clk);
          wr_en   = 1'b0;
        end
        16'h7: begin // rd_en while empty must leave rd_data alone.
          @(negedge rd_clk);
          assert (rd_status.empty)
            else fail_check("fifo not empty before the ignored read.");
          rd_en = 1'b1;
          @(negedge rd_clk);
          rd_en = 1'b0;
          assert (rd_data === val[7:0])
            else fail_check($sformatf("rd_data %02h changed, expected %02h.",
                                      rd_data, val[7:0]));
        end
        16'h8: begin
          @(negedge rd_clk);
          for (int k = 0; k < val[15:8]; k++) pop_word(val[7:0] + k);
        end
        default: abort_run($sformatf("unknown operation code %0h on stimulus line %0d.", op, i));
      endcase
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[17:16]) @(negedge wr_clk);
    end
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verification/fifo_stim.txt ====
// op value: 1 write, 2 read expect, 3 write burst, 4 flags {full afull empty aempty}, 5 idle
// 6 write while full, 7 read while empty, 8 read burst; bursts are count:start in the value
4 0003
1 0011
1 0022
2 0011
1 0033
2 0022
2 0033
4 0003
3 1040
4 000c
6 00ee
4 000c
8 0240
4 0004
2 0042
4 0000
8 0a43
4 0000
2 004d
4 0001
8 024e
4 0003
7 004f
1 005a
2 005a
5 0004
4 0003
0 0000
